/* Bender.yml */
package:
  name: rv_fetch

sources:
  - src/rv_fetch_pkg.sv
  - src/rv_min_idx.sv
  - src/rv_fetch_branch_pred.sv
  - src/rv_fetch_cfg.sv
  - src/rv_fetch_pc.sv
  - src/rv_fetch_top.sv
  - target: test
    files:
      - verification/tb_clkgen.sv
      - verification/rv_fetch_checker.sv
      - verification/rv_fetch_tb.sv

/* list.f */
src/rv_fetch_pkg.sv
src/rv_min_idx.sv
src/rv_fetch_branch_pred.sv
src/rv_fetch_cfg.sv
src/rv_fetch_pc.sv
src/rv_fetch_top.sv
verification/tb_clkgen.sv
verification/rv_fetch_checker.sv
verification/rv_fetch_tb.sv

/* src/rv_fetch_branch_pred.sv */
`timescale 1ns/10ps

module rv_fetch_branch_pred
    import rv_fetch_pkg::*;
(
    input   logic                   i_clk,
    input   logic                   i_reset_n,
    input   logic [IADDR_BITS-1:0]  i_pc_current,
    input   logic                   i_br_update,
    input   logic [IADDR_BITS-1:0]  i_br_pc,
    input   logic [IADDR_BITS-1:0]  i_br_target,
    input   logic                   i_flush,
    output  logic [IADDR_BITS-1:0]  o_pred_target,
    output  logic                   o_pred_hit
);

    logic [IADDR_BITS-1:0] btb_pc [BTB_ENTRIES];
    logic [IADDR_BITS-1:0] btb_tgt [BTB_ENTRIES];
    logic [AGE_BITS-1:0]   btb_age [BTB_ENTRIES];

    logic [AGE_BITS*BTB_ENTRIES-1:0]     age_packed;
    logic [BTB_IDX_BITS*BTB_ENTRIES-1:0] idx_packed;
    logic [BTB_IDX_BITS-1:0]             free_idx;

    logic [BTB_ENTRIES-1:0] hit_hot;    // Lookup match on current PC
    logic [BTB_ENTRIES-1:0] same_hot;   // Entry already holding i_br_pc
    logic [BTB_ENTRIES-1:0] upd_hot;    // Entry written this cycle
    logic [BTB_ENTRIES-1:0] tgt_diff;
    logic                   have_same;
    logic                   tgt_changed;

    genvar i;
    generate
        for (i = 0; i < BTB_ENTRIES; i++)
        begin : pack_gen
            assign age_packed[i*AGE_BITS +: AGE_BITS] = btb_age[i];
            assign idx_packed[i*BTB_IDX_BITS +: BTB_IDX_BITS] = BTB_IDX_BITS'(i);
        end
    endgenerate

    // Oldest entry with the lowest index winning a tie
    rv_min_idx
    #(
        .ELEMENT_WIDTH  (AGE_BITS),
        .INDEX_WIDTH    (BTB_IDX_BITS),
        .ELEMENT_COUNT  (BTB_ENTRIES)
    )
    u_min
    (
        .i_elements     (age_packed),
        .i_idx          (idx_packed),
        .o_min_val      (),
        .o_min_idx      (free_idx)
    );

    assign have_same = |same_hot;
    assign tgt_changed = |(upd_hot & tgt_diff);

    generate
        for (i = 0; i < BTB_ENTRIES; i++)
        begin : entry_gen
            logic                  valid;
            logic [AGE_BITS-2:0]   age_prev;

            assign valid = |btb_age[i];
            assign hit_hot[i] = valid && (btb_pc[i] == i_pc_current);
            assign same_hot[i] = valid && (btb_pc[i] == i_br_pc);
            assign tgt_diff[i] = (btb_tgt[i] != i_br_target);

            assign upd_hot[i] = i_br_update &&
                                (have_same ? same_hot[i] : (free_idx == BTB_IDX_BITS'(i)));

            // History only carries over for the same branch
            assign age_prev = (btb_pc[i] == i_br_pc) ? btb_age[i][AGE_BITS-1:1] : '0;

            always_ff @(posedge i_clk)
            begin
                if (!i_reset_n)
                begin
                    btb_age[i] <= '0;
                end
                else if (i_flush)
                begin
                    btb_age[i] <= '0;
                end
                else if (upd_hot[i])
                begin
                    btb_age[i] <= {1'b1, age_prev};
                end
                else if (tgt_changed)
                begin
                    btb_age[i] <= btb_age[i] >> 1;  // Others grow older
                end
            end

            // A flush drops the whole update
            always_ff @(posedge i_clk)
            begin
                if (upd_hot[i] && !i_flush)
                begin
                    btb_pc[i] <= i_br_pc;
                    btb_tgt[i] <= i_br_target;
                end
            end
        end
    endgenerate

    // At most one valid entry matches a PC
    always_comb
    begin
        o_pred_target = '0;
        for (int k = 0; k < BTB_ENTRIES; k++)
        begin
            o_pred_target = o_pred_target | (btb_tgt[k] & {IADDR_BITS{hit_hot[k]}});
        end
    end

    assign o_pred_hit = |hit_hot;

endmodule

/* src/rv_fetch_cfg.sv */
`timescale 1ns/10ps

module rv_fetch_cfg
    import rv_fetch_pkg::*;
(
    input   logic                       i_clk,
    input   logic                       i_reset_n,
    input   logic                       i_cfg_we,
    input   logic [CFG_ADDR_BITS-1:0]   i_cfg_addr,
    input   logic [31:0]                i_cfg_wdata,
    input   logic                       i_pc_predicted,
    output  logic [31:0]                o_cfg_rdata,
    output  logic                       o_pred_en,
    output  logic                       o_flush
);

    logic [31:0] hit_count;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_pred_en <= 1'b0;
            o_flush <= 1'b0;
            hit_count <= '0;
        end
        else
        begin
            o_flush <= i_cfg_we && (i_cfg_addr == CFG_FLUSH);  // Single cycle pulse

            if (i_cfg_we && (i_cfg_addr == CFG_CTRL))
            begin
                o_pred_en <= i_cfg_wdata[0];
            end

            if (i_cfg_we && (i_cfg_addr == CFG_HITS))
            begin
                hit_count <= '0;        // Any write clears
            end
            else if (i_pc_predicted)
            begin
                hit_count <= hit_count + 32'd1;
            end
        end
    end

    always_comb
    begin
        case (i_cfg_addr)
            CFG_CTRL:   o_cfg_rdata = {31'd0, o_pred_en};
            CFG_HITS:   o_cfg_rdata = hit_count;
            default:    o_cfg_rdata = '0;
        endcase
    end

endmodule

/* src/rv_fetch_pc.sv */
`timescale 1ns/10ps

module rv_fetch_pc
    import rv_fetch_pkg::*;
(
    input   logic                   i_clk,
    input   logic                   i_reset_n,
    input   logic                   i_stall,
    input   logic                   i_redirect,
    input   logic [IADDR_BITS-1:0]  i_redirect_pc,
    input   logic                   i_pred_en,
    input   logic                   i_pred_hit,
    input   logic [IADDR_BITS-1:0]  i_pred_target,
    output  logic [IADDR_BITS-1:0]  o_pc,
    output  logic                   o_pc_predicted
);

    logic [IADDR_BITS-1:0] pc_next;
    logic                  take_pred;

    // Redirect wins over stall, stall blocks prediction
    assign take_pred = !i_redirect && !i_stall && i_pred_en && i_pred_hit;
    assign o_pc_predicted = take_pred;

    always_comb
    begin
        if (i_redirect)
        begin
            pc_next = i_redirect_pc;
        end
        else if (i_stall)
        begin
            pc_next = o_pc;
        end
        else if (take_pred)
        begin
            pc_next = i_pred_target;
        end
        else
        begin
            pc_next = o_pc + IADDR_BITS'(4);   // Sequential
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_pc <= RESET_PC;
        end
        else
        begin
            o_pc <= pc_next;
        end
    end

endmodule

/* src/rv_fetch_pkg.sv */
package rv_fetch_pkg;

    // Instruction address space
    localparam int IADDR_BITS = 32;

    // Branch target buffer geometry
    localparam int BTB_IDX_BITS = 4;
    localparam int BTB_ENTRIES = 16;

    // One age bit per entry, newest training sets the top bit
    localparam int AGE_BITS = BTB_ENTRIES;

    // First fetch address out of reset
    localparam logic [IADDR_BITS-1:0] RESET_PC = 32'h0000_1000;

    // Configuration port
    localparam int CFG_ADDR_BITS = 2;

    localparam logic [CFG_ADDR_BITS-1:0] CFG_CTRL = 2'd0;   // Bit 0 predictor enable
    localparam logic [CFG_ADDR_BITS-1:0] CFG_FLUSH = 2'd1;  // Write only, reads zero
    localparam logic [CFG_ADDR_BITS-1:0] CFG_HITS = 2'd2;   // Predicted fetch count

endpackage

/* src/rv_fetch_top.sv */
`timescale 1ns/10ps

module rv_fetch_top
    import rv_fetch_pkg::*;
(
    input   logic                       i_clk,
    input   logic                       i_reset_n,
    input   logic                       i_stall,
    input   logic                       i_redirect,
    input   logic [IADDR_BITS-1:0]      i_redirect_pc,
    input   logic                       i_br_update,
    input   logic [IADDR_BITS-1:0]      i_br_pc,
    input   logic [IADDR_BITS-1:0]      i_br_target,
    input   logic                       i_cfg_we,
    input   logic [CFG_ADDR_BITS-1:0]   i_cfg_addr,
    input   logic [31:0]                i_cfg_wdata,
    output  logic [IADDR_BITS-1:0]      o_pc,
    output  logic                       o_pc_predicted,
    output  logic [31:0]                o_cfg_rdata
);

    logic                  cfg_flush;
    logic                  cfg_pred_en;
    logic                  pred_hit;
    logic [IADDR_BITS-1:0] pred_target;

    rv_fetch_cfg u_cfg
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_cfg_we       (i_cfg_we),
        .i_cfg_addr     (i_cfg_addr),
        .i_cfg_wdata    (i_cfg_wdata),
        .i_pc_predicted (o_pc_predicted),
        .o_cfg_rdata    (o_cfg_rdata),
        .o_pred_en      (cfg_pred_en),
        .o_flush        (cfg_flush)
    );

    // Lookup runs on the PC being fetched now
    rv_fetch_branch_pred u_btb
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_pc_current   (o_pc),
        .i_br_update    (i_br_update),
        .i_br_pc        (i_br_pc),
        .i_br_target    (i_br_target),
        .i_flush        (cfg_flush),
        .o_pred_target  (pred_target),
        .o_pred_hit     (pred_hit)
    );

    rv_fetch_pc u_pc
    (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_stall        (i_stall),
        .i_redirect     (i_redirect),
        .i_redirect_pc  (i_redirect_pc),
        .i_pred_en      (cfg_pred_en),
        .i_pred_hit     (pred_hit),
        .i_pred_target  (pred_target),
        .o_pc           (o_pc),
        .o_pc_predicted (o_pc_predicted)
    );

endmodule

/* src/rv_min_idx.sv */
`timescale 1ns/10ps

module rv_min_idx
#(
    parameter int ELEMENT_WIDTH = 16,
    parameter int INDEX_WIDTH = 4,
    parameter int ELEMENT_COUNT = 16
)
(
    input   logic [ELEMENT_WIDTH*ELEMENT_COUNT-1:0] i_elements,
    input   logic [INDEX_WIDTH*ELEMENT_COUNT-1:0]   i_idx,
    output  logic [ELEMENT_WIDTH-1:0]               o_min_val,
    output  logic [INDEX_WIDTH-1:0]                 o_min_idx
);

    // Heap ordered tree, node k has children 2k+1 and 2k+2
    localparam int NODE_COUNT = 2 * ELEMENT_COUNT - 1;

    logic [ELEMENT_WIDTH-1:0] node_val [NODE_COUNT];
    logic [INDEX_WIDTH-1:0]   node_idx [NODE_COUNT];

    genvar j;
    generate
        for (j = 0; j < ELEMENT_COUNT; j++)
        begin : leaf_gen
            assign node_val[ELEMENT_COUNT-1+j] = i_elements[j*ELEMENT_WIDTH +: ELEMENT_WIDTH];
            assign node_idx[ELEMENT_COUNT-1+j] = i_idx[j*INDEX_WIDTH +: INDEX_WIDTH];
        end

        for (j = 0; j < ELEMENT_COUNT - 1; j++)
        begin : node_gen
            logic take_left;

            // Equal values resolve to the lower carried index
            assign take_left = (node_val[2*j+1] < node_val[2*j+2]) ||
                               ((node_val[2*j+1] == node_val[2*j+2]) &&
                                (node_idx[2*j+1] <= node_idx[2*j+2]));

            assign node_val[j] = take_left ? node_val[2*j+1] : node_val[2*j+2];
            assign node_idx[j] = take_left ? node_idx[2*j+1] : node_idx[2*j+2];
        end
    endgenerate

    assign o_min_val = node_val[0];
    assign o_min_idx = node_idx[0];

endmodule

/* verification/rv_fetch_checker.sv */
`timescale 1ns/10ps

module rv_fetch_checker
    import rv_fetch_pkg::*;
(
    input   logic                       i_clk,
    input   logic                       i_reset_n,
    input   logic                       i_redirect,
    input   logic [IADDR_BITS-1:0]      i_redirect_pc,
    input   logic [CFG_ADDR_BITS-1:0]   i_cfg_addr,
    input   logic [31:0]                i_cfg_rdata,
    input   logic [IADDR_BITS-1:0]      i_pc,
    input   logic                       i_pc_predicted
);

    int fail_count = 0;     // Read by the testbench top

    a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_pc[1:0] == 2'b00)
    else
    begin
        $error("fetch pc %h is not word aligned", i_pc);
        fail_count++;
    end

    a_redirect_pc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_redirect |=> (i_pc == $past(i_redirect_pc)))
    else
    begin
        $error("fetch pc did not follow the redirect");
        fail_count++;
    end

    // Enable visible only while CFG_CTRL is addressed
    a_pred_disabled: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        ((i_cfg_addr == CFG_CTRL) && !i_cfg_rdata[0]) |-> !i_pc_predicted)
    else
    begin
        $error("prediction taken while the predictor is disabled");
        fail_count++;
    end

endmodule

bind rv_fetch_top rv_fetch_checker chk0
(
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_redirect     (i_redirect),
    .i_redirect_pc  (i_redirect_pc),
    .i_cfg_addr     (i_cfg_addr),
    .i_cfg_rdata    (o_cfg_rdata),
    .i_pc           (o_pc),
    .i_pc_predicted (o_pc_predicted)
);

/* verification/rv_fetch_tb.sv */
`timescale 1ns/10ps

module rv_fetch_tb
    import rv_fetch_pkg::*;
();

    localparam int SEQ_CYCLES = 60;
    localparam int DIS_CYCLES = 40;
    localparam int TRAIN_COUNT = 12;
    localparam int REPL_COUNT = 24;
    localparam int TIMEOUT_CYCLES = 8 + SEQ_CYCLES + DIS_CYCLES + 20 + TRAIN_COUNT * 4
                                    + REPL_COUNT * 3 + 40 + 100;

    logic clk, reset_n;
    logic stall, redirect, br_update, cfg_we;
    logic [31:0] redirect_pc, br_pc, br_target, cfg_wdata, fetch_pc, cfg_rdata;
    logic [CFG_ADDR_BITS-1:0] cfg_addr;
    logic pc_predicted;

    // Values for the next cycle, strobes fall back to idle after each tick
    logic n_stall, n_redirect, n_br_update, n_cfg_we;
    logic [31:0] n_redirect_pc, n_br_pc, n_br_target, n_cfg_wdata;
    logic [CFG_ADDR_BITS-1:0] n_cfg_addr, read_addr;

    // Reference model
    logic [31:0] exp_pc, m_count;
    logic [31:0] e_pc [BTB_ENTRIES];
    logic [31:0] e_tgt [BTB_ENTRIES];
    logic [AGE_BITS-1:0] e_age [BTB_ENTRIES];
    logic m_en, m_flush_pend;

    integer seed;
    string test_name;
    int err_count = 0;
    int check_count = 0;
    int test_start, tests_run, tests_failed;
    int cycle_count = 0;
    logic [31:0] trained [REPL_COUNT];
    logic [31:0] addr, tgt;

    tb_clkgen #(.PERIOD_NS(10.0), .RESET_CYCLES(8)) u_clk (.o_clk(clk), .o_reset_n(reset_n));

    rv_fetch_top dut0
    (
        .i_clk(clk), .i_reset_n(reset_n), .i_stall(stall), .i_redirect(redirect),
        .i_redirect_pc(redirect_pc), .i_br_update(br_update), .i_br_pc(br_pc),
        .i_br_target(br_target), .i_cfg_we(cfg_we), .i_cfg_addr(cfg_addr),
        .i_cfg_wdata(cfg_wdata), .o_pc(fetch_pc), .o_pc_predicted(pc_predicted),
        .o_cfg_rdata(cfg_rdata)
    );

    function automatic logic [31:0] rand_word();
        return $random(seed) & 32'hFFFF_FFFC;
    endfunction

    function automatic logic rand_bit();
        return 1'($random(seed));
    endfunction

    function automatic int find_entry(input logic [31:0] a);
        for (int k = 0; k < BTB_ENTRIES; k++)
        begin
            if ((e_age[k] != '0) && (e_pc[k] == a))
                return k;
        end
        return -1;
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (exp !== act)
        begin
            err_count++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // Training per the replacement rules
    task automatic model_train(input logic [31:0] a, input logic [31:0] t);
        int sel;
        logic [AGE_BITS-1:0] prev;
        logic changed;
        sel = find_entry(a);
        if (sel < 0)
        begin
            sel = 0;
            for (int k = 1; k < BTB_ENTRIES; k++)
                if (e_age[k] < e_age[sel])
                    sel = k;
        end
        prev = (e_pc[sel] == a) ? e_age[sel] : '0;
        changed = (e_tgt[sel] != t);
        for (int k = 0; k < BTB_ENTRIES; k++)
            if (changed && (k != sel))
                e_age[k] = e_age[k] >> 1;
        e_age[sel] = {1'b1, prev[AGE_BITS-1:1]};
        e_pc[sel] = a;
        e_tgt[sel] = t;
    endtask

    // Check the cycle now on the pins, then advance the model past the next edge
    task automatic evaluate();
        int hit;
        logic pred;
        logic [31:0] rd;
        hit = find_entry(exp_pc);
        pred = !redirect && !stall && m_en && (hit >= 0);
        rd = (cfg_addr == CFG_CTRL) ? {31'd0, m_en} : (cfg_addr == CFG_HITS) ? m_count : '0;
        compare("pc", exp_pc, fetch_pc);
        compare("predicted", 32'(pred), 32'(pc_predicted));
        compare("readback", rd, cfg_rdata);
        if (redirect)
            exp_pc = redirect_pc;
        else if (pred)
            exp_pc = e_tgt[hit];
        else if (!stall)
            exp_pc = exp_pc + 32'd4;
        if (cfg_we && (cfg_addr == CFG_HITS))
            m_count = '0;
        else if (pred)
            m_count = m_count + 32'd1;
        if (cfg_we && (cfg_addr == CFG_CTRL))
            m_en = cfg_wdata[0];
        if (m_flush_pend)
        begin
            for (int k = 0; k < BTB_ENTRIES; k++)
                e_age[k] = '0;      // Flush beats a same cycle update
        end
        else if (br_update)
            model_train(br_pc, br_target);
        m_flush_pend = cfg_we && (cfg_addr == CFG_FLUSH);
    endtask

    task automatic tick();
        @(posedge clk);
        stall <= n_stall;
        redirect <= n_redirect;
        redirect_pc <= n_redirect_pc;
        br_update <= n_br_update;
        br_pc <= n_br_pc;
        br_target <= n_br_target;
        cfg_we <= n_cfg_we;
        cfg_addr <= n_cfg_we ? n_cfg_addr : read_addr;
        cfg_wdata <= n_cfg_wdata;
        {n_stall, n_redirect, n_br_update, n_cfg_we} = '0;
        @(negedge clk);
        evaluate();
    endtask

    task automatic cfg_write(input logic [CFG_ADDR_BITS-1:0] a, input logic [31:0] d);
        n_cfg_we = 1'b1;
        n_cfg_addr = a;
        n_cfg_wdata = d;
        tick();
    endtask

    task automatic train(input logic [31:0] a, input logic [31:0] t);
        n_br_update = 1'b1;
        n_br_pc = a;
        n_br_target = t;
        tick();
    endtask

    // Redirect to a branch PC, then look at the cycle that fetches it
    task automatic probe(input logic [31:0] a, input logic exp_hit);
        n_redirect = 1'b1;
        n_redirect_pc = a;
        tick();
        tick();
        compare("probe hit", 32'(exp_hit), 32'(pc_predicted));
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_start = err_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_count == test_start)
            $display("test %s: ok", test_name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, err_count - test_start);
        end
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: tests still running after %0d cycles", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial
    begin
        seed = 32'h5a6d;
        {stall, redirect, br_update, cfg_we} = '0;
        {redirect_pc, br_pc, br_target, cfg_wdata} = '0;
        {n_stall, n_redirect, n_br_update, n_cfg_we} = '0;
        {n_redirect_pc, n_br_pc, n_br_target, n_cfg_wdata} = '0;
        read_addr = CFG_HITS;
        cfg_addr = CFG_HITS;
        n_cfg_addr = CFG_HITS;
        {tests_run, tests_failed} = '0;
        exp_pc = RESET_PC;
        {m_count, m_en, m_flush_pend} = '0;
        for (int k = 0; k < BTB_ENTRIES; k++)
            {e_pc[k], e_tgt[k], e_age[k]} = '0;

        @(posedge reset_n);
        @(negedge clk);
        begin_test("reset_sequential");
        compare("reset pc", RESET_PC, fetch_pc);
        evaluate();
        for (int k = 0; k < SEQ_CYCLES; k++)
        begin
            n_stall = rand_bit();
            tick();
        end
        end_test();

        begin_test("disabled_predictor");
        read_addr = CFG_CTRL;
        cfg_write(CFG_CTRL, 32'd0);
        addr = exp_pc + 32'h20;     // Branches just ahead of the fetch stream
        for (int k = 0; k < BTB_ENTRIES; k++)
        begin
            n_stall = rand_bit();
            train(addr + 32'(k * 4), rand_word());
        end
        for (int k = 0; k < DIS_CYCLES; k++)
        begin
            n_stall = rand_bit();
            tick();
            compare("no prediction", 32'd0, 32'(pc_predicted));
        end
        cfg_write(CFG_FLUSH, 32'd0);
        tick();
        read_addr = CFG_HITS;
        end_test();

        begin_test("trained_prediction");
        cfg_write(CFG_CTRL, 32'd1);
        for (int k = 0; k < TRAIN_COUNT; k++)
        begin
            if (k % 3 != 2)
                addr = rand_word();     // Every third pass retrains the last PC
            tgt = rand_word();
            train(addr, tgt);
            probe(addr, 1'b1);
            tick();
            compare("target", tgt, fetch_pc);
        end
        end_test();

        begin_test("replacement");
        for (int k = 0; k < REPL_COUNT; k++)
        begin
            trained[k] = rand_word();
            n_stall = rand_bit();
            train(trained[k], rand_word());
        end
        for (int k = 0; k < REPL_COUNT; k++)
            probe(trained[k], find_entry(trained[k]) >= 0);
        end_test();

        begin_test("flush_counter");
        cfg_write(CFG_HITS, 32'd0);
        for (int k = 0; k < 4; k++)
        begin
            trained[k] = rand_word();
            train(trained[k], rand_word());
        end
        for (int k = 0; k < 4; k++)
            probe(trained[k], 1'b1);
        tick();
        compare("hit count", m_count, cfg_rdata);
        cfg_write(CFG_FLUSH, 32'd0);
        addr = rand_word();
        train(addr, rand_word());   // Lands on the flush pulse
        for (int k = 0; k < 4; k++)
            probe(trained[k], 1'b0);
        probe(addr, 1'b0);
        cfg_write(CFG_HITS, 32'd1);
        tick();
        compare("cleared count", 32'd0, cfg_rdata);
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, check_count, err_count, dut0.chk0.fail_count);
        if ((err_count == 0) && (dut0.chk0.fail_count == 0))
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* verification/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen
#(
    parameter real PERIOD_NS = 10.0,
    parameter int RESET_CYCLES = 8
)
(
    output  logic   o_clk,
    output  logic   o_reset_n
);

    initial
    begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

    // Release on a rising edge, seen by the DUT one edge later
    initial
    begin
        o_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset_n <= 1'b1;
    end

endmodule
